// File: hdl/isa_pkg.sv
package isa_pkg;

    // Datapath widths
    localparam int INSTR_SIZE  = 32;
    localparam int ADDR_SIZE   = 32;    // PC and immediate
    localparam int REG_SIZE    = 32;
    localparam int REG_ADDR    = 5;
    localparam int NUM_REGS    = 32;
    localparam int OPCODE_SIZE = 6;
    localparam int FUNCT_SIZE  = 6;

    // Field positions, low bit of each field
    localparam int OPCODE_LSB = 26;     // 31:26
    localparam int SRC1_LSB   = 21;     // 25:21
    localparam int SRC2_LSB   = 16;     // 20:16
    localparam int DEST_LSB   = 11;     // 15:11
    localparam int FUNCT_LSB  = 0;      // 5:0

    // Primary opcodes, codes past OP_NOP decode as NOP
    typedef enum logic [OPCODE_SIZE-1:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd1,
        OP_LDW   = 6'd2,
        OP_LDB   = 6'd3,
        OP_STW   = 6'd4,
        OP_STB   = 6'd5,
        OP_BEQ   = 6'd6,
        OP_JUMP  = 6'd7,
        OP_NOP   = 6'd8
    } opcode_e;

    // R-type function codes
    typedef enum logic [FUNCT_SIZE-1:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_MUL = 6'd2
    } funct_e;

endpackage

// File: hdl/pipe_pkg.sv
package pipe_pkg;

    // Minimum spacing between two multiply issues
    localparam int MULT_CYCLES = 4;

    // Timer runs after the FSM has seen is_mult, so two cycles are already spent
    localparam int MULT_TIMER_LOAD = MULT_CYCLES - 2;
    localparam int MULT_TIMER_SIZE = $clog2(MULT_CYCLES);

    // Multiplier occupancy
    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_BUSY
    } issue_state_e;

endpackage

// File: hdl/register_file.sv
module register_file (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [isa_pkg::REG_ADDR-1:0] rd_addr1,
    input  logic [isa_pkg::REG_ADDR-1:0] rd_addr2,
    input  logic                         wr_en,
    input  logic [isa_pkg::REG_ADDR-1:0] wr_addr,
    input  logic [isa_pkg::REG_SIZE-1:0] wr_data,
    output logic [isa_pkg::REG_SIZE-1:0] rd_data1,
    output logic [isa_pkg::REG_SIZE-1:0] rd_data2
);
    import isa_pkg::*;

    logic [REG_SIZE-1:0] regs [NUM_REGS];

    // Bank is cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin  // r0 never stored
            regs[wr_addr] <= wr_data;
        end
    end

    // Read port 1, r0 first, then bypass from writeback
    assign rd_data1 = (rd_addr1 == '0)                  ? '0      :
                      (wr_en && wr_addr == rd_addr1)    ? wr_data :
                                                          regs[rd_addr1];

    // Read port 2, same priority
    assign rd_data2 = (rd_addr2 == '0)                  ? '0      :
                      (wr_en && wr_addr == rd_addr2)    ? wr_data :
                                                          regs[rd_addr2];

endmodule

// File: hdl/control.sv
module control (
    input  logic             clk,
    input  logic             reset,
    input  isa_pkg::opcode_e opcode,
    input  isa_pkg::funct_e  funct,
    input  logic             stall,
    output logic             mult_request,
    output logic             regwrite,   // WB: write the register file
    output logic             memtoreg,   // WB: result from memory, not ALU
    output logic             branch,     // M: PC mux select
    output logic             memwrite,
    output logic             memread,
    output logic             byteword,   // M: 1 word, 0 byte
    output logic             alusrc,     // EX: immediate as operand 2
    output logic             is_mult
);
    import isa_pkg::*;

    // Order: regwrite, memtoreg, branch, memwrite, memread, byteword, alusrc
    logic [6:0] ctl_next;

    always_comb begin
        case (opcode)
            OP_RTYPE: ctl_next = 7'b1000000;
            OP_ADDI:  ctl_next = 7'b1000001;
            OP_LDW:   ctl_next = 7'b1100111;
            OP_LDB:   ctl_next = 7'b1100101;
            OP_STW:   ctl_next = 7'b0001011;
            OP_STB:   ctl_next = 7'b0001001;
            OP_BEQ:   ctl_next = 7'b0010000;
            OP_JUMP:  ctl_next = 7'b0010000;
            default:  ctl_next = 7'b0000000;   // OP_NOP and undefined codes
        endcase
    end

    // Raised even during a stall, the hazard unit needs it to hold the stall
    assign mult_request = (opcode == OP_RTYPE) && (funct == FN_MUL);

    // Control half of ID/EX
    always_ff @(posedge clk) begin
        if (reset) begin
            {regwrite, memtoreg, branch, memwrite, memread, byteword, alusrc} <= '0;
            is_mult <= 1'b0;
        end else if (stall) begin
            // Bubble into EX
            {regwrite, memtoreg, branch, memwrite, memread, byteword, alusrc} <= '0;
            is_mult <= 1'b0;
        end else begin
            {regwrite, memtoreg, branch, memwrite, memread, byteword, alusrc} <= ctl_next;
            is_mult <= mult_request;
        end
    end

endmodule

// File: hdl/hazard_control.sv
module hazard_control (
    input  logic [isa_pkg::REG_ADDR-1:0] src1,
    input  logic [isa_pkg::REG_ADDR-1:0] src2,
    input  logic                         ex_regwrite,
    input  logic [isa_pkg::REG_ADDR-1:0] ex_dest_reg,
    input  logic                         m_regwrite,
    input  logic [isa_pkg::REG_ADDR-1:0] m_dest_reg,
    input  logic                         mult_request,
    input  logic                         mult_busy,
    output logic                         stall
);
    import isa_pkg::*;

    logic raw_hazard;
    logic mult_hazard;

    // Pending write to a source, r0 never conflicts
    function automatic logic dep(input logic [REG_ADDR-1:0] src,
                                 input logic [REG_ADDR-1:0] dest,
                                 input logic                wr);
        return wr && (src != '0) && (src == dest);
    endfunction

    // No forwarding, so any hit in EX or M has to wait
    assign raw_hazard = dep(src1, ex_dest_reg, ex_regwrite) ||
                        dep(src2, ex_dest_reg, ex_regwrite) ||
                        dep(src1, m_dest_reg, m_regwrite)   ||
                        dep(src2, m_dest_reg, m_regwrite);

    // Multiplier still occupied by the previous multiply
    assign mult_hazard = mult_request && mult_busy;

    assign stall = raw_hazard || mult_hazard;

endmodule

// File: hdl/mult_issue_fsm.sv
module mult_issue_fsm (
    input  logic clk,
    input  logic reset,
    input  logic is_mult,      // Multiply sitting in ID/EX this cycle
    input  logic timer_done,
    output logic timer_load,
    output logic mult_busy
);
    import pipe_pkg::*;

    issue_state_e state;
    issue_state_e next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ISSUE_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ISSUE_IDLE: begin
                if (is_mult) begin
                    next_state = ISSUE_BUSY;
                end
            end
            ISSUE_BUSY: begin
                if (timer_done) begin
                    next_state = ISSUE_IDLE;     // Next multiply may issue
                end
            end
            default: next_state = ISSUE_IDLE;
        endcase
    end

    // One-cycle pulse as the FSM leaves idle
    assign timer_load = (state == ISSUE_IDLE) && is_mult;

    // Busy already in the cycle of is_mult, the FSM is still idle then
    assign mult_busy = is_mult || (state == ISSUE_BUSY);

endmodule

// File: hdl/mult_latency_timer.sv
module mult_latency_timer (
    input  logic clk,
    input  logic reset,
    input  logic load,
    output logic done
);
    import pipe_pkg::*;

    logic [MULT_TIMER_SIZE-1:0] count;

    // Counts down and parks at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= MULT_TIMER_SIZE'(MULT_TIMER_LOAD);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Last busy cycle
    assign done = (count == MULT_TIMER_SIZE'(1));

endmodule

// File: hdl/decode_stage.sv
module decode_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [isa_pkg::ADDR_SIZE-1:0]   pc,
    input  logic [isa_pkg::INSTR_SIZE-1:0]  instruction,
    input  logic [isa_pkg::REG_SIZE-1:0]    rd_data1,     // From register file
    input  logic [isa_pkg::REG_SIZE-1:0]    rd_data2,
    output logic [isa_pkg::REG_ADDR-1:0]    src_reg1,
    output logic [isa_pkg::REG_ADDR-1:0]    src_reg2,
    output isa_pkg::opcode_e                opcode,       // To control
    output isa_pkg::funct_e                 funct,
    output logic [isa_pkg::ADDR_SIZE-1:0]   out_pc,
    output logic [isa_pkg::REG_SIZE-1:0]    rout_reg1,
    output logic [isa_pkg::REG_SIZE-1:0]    rout_reg2,
    output logic [isa_pkg::REG_ADDR-1:0]    dest_reg,
    output logic [isa_pkg::ADDR_SIZE-1:0]   mimmediat,
    output logic [isa_pkg::OPCODE_SIZE-1:0] op_code,
    output logic [isa_pkg::FUNCT_SIZE-1:0]  funct_code
);
    import isa_pkg::*;

    logic [REG_ADDR-1:0]  dst;
    logic [ADDR_SIZE-1:0] imm;

    // Field split
    assign opcode   = opcode_e'(instruction[OPCODE_LSB +: OPCODE_SIZE]);
    assign funct    = funct_e'(instruction[FUNCT_LSB +: FUNCT_SIZE]);
    assign src_reg1 = instruction[SRC1_LSB +: REG_ADDR];
    assign src_reg2 = instruction[SRC2_LSB +: REG_ADDR];
    assign dst      = instruction[DEST_LSB +: REG_ADDR];

    // Immediate format depends on the opcode
    always_comb begin
        case (opcode)
            OP_BEQ: begin
                // Branch offset, high part shares the src2 slot
                imm = {{(ADDR_SIZE-15){instruction[24]}}, instruction[24:20],
                       instruction[9:0]};
            end
            OP_JUMP: begin
                // 20-bit jump target
                imm = {{(ADDR_SIZE-20){instruction[24]}}, instruction[24:20],
                       instruction[14:0]};
            end
            default: begin
                imm = {{(ADDR_SIZE-15){instruction[14]}}, instruction[14:0]};
            end
        endcase
    end

    // Data half of ID/EX, loads every edge
    always_ff @(posedge clk) begin
        if (reset) begin
            out_pc     <= '0;
            rout_reg1  <= '0;
            rout_reg2  <= '0;
            dest_reg   <= '0;
            mimmediat  <= '0;
            op_code    <= '0;
            funct_code <= '0;
        end else begin
            out_pc     <= pc;         // Passed on for branch target
            rout_reg1  <= rd_data1;
            rout_reg2  <= rd_data2;
            dest_reg   <= dst;
            mimmediat  <= imm;
            op_code    <= opcode;
            funct_code <= funct;
        end
    end

endmodule

// File: hdl/decode_top.sv
module decode_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [isa_pkg::ADDR_SIZE-1:0]   pc,
    input  logic [isa_pkg::INSTR_SIZE-1:0]  instruction,
    input  logic                            ex_regwrite,
    input  logic [isa_pkg::REG_ADDR-1:0]    ex_dest_reg,
    input  logic                            m_regwrite,
    input  logic [isa_pkg::REG_ADDR-1:0]    m_dest_reg,
    input  logic                            wb_regwrite,
    input  logic [isa_pkg::REG_ADDR-1:0]    wb_dest_reg,
    input  logic [isa_pkg::REG_SIZE-1:0]    wb_data,
    output logic [isa_pkg::ADDR_SIZE-1:0]   out_pc,
    output logic [isa_pkg::REG_SIZE-1:0]    rout_reg1,
    output logic [isa_pkg::REG_SIZE-1:0]    rout_reg2,
    output logic [isa_pkg::REG_ADDR-1:0]    dest_reg,
    output logic [isa_pkg::ADDR_SIZE-1:0]   mimmediat,
    output logic [isa_pkg::OPCODE_SIZE-1:0] op_code,
    output logic [isa_pkg::FUNCT_SIZE-1:0]  funct_code,
    output logic                            regwrite,
    output logic                            memtoreg,
    output logic                            branch,
    output logic                            memwrite,
    output logic                            memread,
    output logic                            byteword,
    output logic                            alusrc,
    output logic                            is_mult,
    output logic                            pc_write,     // Low holds fetch
    output logic                            if_id_write
);
    import isa_pkg::*;

    logic [REG_ADDR-1:0] src_reg1;
    logic [REG_ADDR-1:0] src_reg2;
    logic [REG_SIZE-1:0] rd_data1;
    logic [REG_SIZE-1:0] rd_data2;
    opcode_e             opcode;
    funct_e              funct;
    logic                mult_request;
    logic                mult_busy;
    logic                timer_load;
    logic                timer_done;
    logic                stall;

    decode_stage u_stage (
        .clk, .reset, .pc, .instruction, .rd_data1, .rd_data2,
        .src_reg1, .src_reg2, .opcode, .funct,
        .out_pc, .rout_reg1, .rout_reg2, .dest_reg, .mimmediat, .op_code, .funct_code
    );

    // Writeback drives the write port
    register_file u_regs (
        .clk, .reset,
        .rd_addr1 (src_reg1),    .rd_addr2 (src_reg2),
        .wr_en    (wb_regwrite), .wr_addr  (wb_dest_reg), .wr_data (wb_data),
        .rd_data1,               .rd_data2
    );

    control u_control (
        .clk, .reset, .opcode, .funct, .stall, .mult_request,
        .regwrite, .memtoreg, .branch, .memwrite, .memread, .byteword, .alusrc, .is_mult
    );

    hazard_control u_hazard (
        .src1 (src_reg1), .src2 (src_reg2),
        .ex_regwrite, .ex_dest_reg, .m_regwrite, .m_dest_reg,
        .mult_request, .mult_busy, .stall
    );

    mult_issue_fsm u_mult_fsm (
        .clk, .reset, .is_mult, .timer_done, .timer_load, .mult_busy
    );

    mult_latency_timer u_mult_timer (
        .clk, .reset, .load (timer_load), .done (timer_done)
    );

    // Stall freezes PC and IF/ID
    assign pc_write    = ~stall;
    assign if_id_write = ~stall;

endmodule

// File: test/decode_tb.sv
module decode_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                   clk = 1'b0;
    logic                   reset;
    logic [ADDR_SIZE-1:0]   pc;
    logic [INSTR_SIZE-1:0]  instruction;
    logic                   ex_regwrite;
    logic [REG_ADDR-1:0]    ex_dest_reg;
    logic                   m_regwrite;
    logic [REG_ADDR-1:0]    m_dest_reg;
    logic                   wb_regwrite;
    logic [REG_ADDR-1:0]    wb_dest_reg;
    logic [REG_SIZE-1:0]    wb_data;
    logic [ADDR_SIZE-1:0]   out_pc;
    logic [REG_SIZE-1:0]    rout_reg1;
    logic [REG_SIZE-1:0]    rout_reg2;
    logic [REG_ADDR-1:0]    dest_reg;
    logic [ADDR_SIZE-1:0]   mimmediat;
    logic [OPCODE_SIZE-1:0] op_code;
    logic [FUNCT_SIZE-1:0]  funct_code;
    logic regwrite, memtoreg, branch, memwrite, memread, byteword, alusrc, is_mult;
    logic pc_write, if_id_write;

    logic [31:0] seed = 32'ha057_8d21;
    int errors = 0;
    int tests = 0;
    int failed_tests = 0;
    int errors_at_start = 0;            // Error count when the current test began

    wire [6:0] ctrl_out = {regwrite, memtoreg, branch, memwrite, memread, byteword, alusrc};

    decode_top dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    function automatic logic [31:0] make_instr(input logic [5:0] op, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [4:0] rd,
                                               input logic [5:0] fn);
        return {op, rs1, rs2, rd, 5'b0, fn};
    endfunction

    // Bits ordered regwrite, memtoreg, branch, memwrite, memread, byteword, alusrc
    function automatic logic [6:0] expected_ctrl(input logic [5:0] op);
        case (op)
            OP_RTYPE: return 7'b1000000;
            OP_ADDI:  return 7'b1000001;
            OP_LDW:   return 7'b1100111;
            OP_LDB:   return 7'b1100101;
            OP_STW:   return 7'b0001011;
            OP_STB:   return 7'b0001001;
            OP_BEQ:   return 7'b0010000;
            OP_JUMP:  return 7'b0010000;
            default:  return 7'b0000000;   // NOP and unknown
        endcase
    endfunction

    function automatic logic [31:0] expected_imm(input logic [31:0] ins);
        case (ins[31:26])
            OP_BEQ:  return {{17{ins[24]}}, ins[24:20], ins[9:0]};
            OP_JUMP: return {{12{ins[24]}}, ins[24:20], ins[14:0]};
            default: return {{17{ins[14]}}, ins[14:0]};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != errors_at_start) begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - errors_at_start);
        end else begin
            $display("%s: passed", name);
        end
        errors_at_start = errors;
    endtask

    // One instruction checked after the ID/EX edge
    task automatic present(input logic [31:0] ins, input logic [31:0] addr);
        @(posedge clk);
        instruction <= ins;
        pc          <= addr;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_ready(input string name);
        int n;
        n = 0;
        while (pc_write !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (pc_write !== 1'b1) begin
            $display("%s: timed out waiting for pc_write", name);
            errors++;
        end
    endtask

    task automatic reset_state();
        check_value("reset_state ctrl", 32'(7'b0), 32'(ctrl_out));
        check_value("reset_state is_mult", 32'(1'b0), 32'(is_mult));
        check_value("reset_state pc_write", 32'(1'b1), 32'(pc_write));
        check_value("reset_state if_id_write", 32'(1'b1), 32'(if_id_write));
        check_value("reset_state out_pc", 32'h0, out_pc);
        check_value("reset_state dest_reg", 32'h0, 32'(dest_reg));
        check_value("reset_state funct_code", 32'h0, 32'(funct_code));
        check_value("reset_state mimmediat", 32'h0, mimmediat);
        end_test("reset_state");
    endtask

    task automatic field_decode();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] ins;
        logic [5:0]  op;
        for (int i = 0; i <= 10; i++) begin
            op   = (i == 10) ? 6'd63 : 6'(i);       // 9 and 63 are unknown
            r    = xorshift();
            addr = xorshift();
            ins  = make_instr(op, 5'd0, 5'd0, r[4:0], FN_SUB);
            present(ins, addr);
            check_value("field_decode ctrl", 32'(expected_ctrl(op)), 32'(ctrl_out));
            check_value("field_decode is_mult", 32'(1'b0), 32'(is_mult));
            check_value("field_decode op_code", 32'(op), 32'(op_code));
            check_value("field_decode funct_code", 32'(FN_SUB), 32'(funct_code));
            check_value("field_decode dest_reg", 32'(r[4:0]), 32'(dest_reg));
            check_value("field_decode out_pc", addr, out_pc);
        end
        end_test("field_decode");
    endtask

    task automatic immediate_gen();
        logic [31:0] r;
        logic [31:0] ins;
        logic [5:0]  op;
        for (int i = 0; i < 12; i++) begin
            r  = xorshift();
            case (i % 4)
                0:       op = OP_BEQ;
                1:       op = OP_JUMP;
                2:       op = OP_ADDI;
                default: op = OP_LDW;
            endcase
            ins = {op, r[25:0]};                // No pending writes and no stall
            present(ins, 32'h0);
            check_value("immediate_gen mimmediat", expected_imm(ins), mimmediat);
        end
        end_test("immediate_gen");
    endtask

    task automatic regfile_access();
        logic [31:0] vals [32];
        logic [31:0] v;
        vals[0] = 32'h0;
        for (int k = 1; k < 32; k++) begin
            vals[k] = xorshift();
            @(posedge clk);
            wb_regwrite <= 1'b1;
            wb_dest_reg <= 5'(k);
            wb_data     <= vals[k];
        end
        @(posedge clk);
        wb_regwrite <= 1'b0;                     // Last write lands here
        for (int k = 1; k < 32; k++) begin
            present(make_instr(OP_ADDI, 5'(k), 5'(32 - k), 5'd0, FN_ADD), 32'h0);
            check_value("regfile_access port1", vals[k], rout_reg1);
            check_value("regfile_access port2", vals[32 - k], rout_reg2);
        end
        // Same-cycle write and read
        v = xorshift();
        @(posedge clk);
        instruction <= make_instr(OP_ADDI, 5'd9, 5'd9, 5'd0, FN_ADD);
        wb_regwrite <= 1'b1;
        wb_dest_reg <= 5'd9;
        wb_data     <= v;
        @(posedge clk);
        wb_regwrite <= 1'b0;
        @(negedge clk);
        check_value("regfile_access bypass1", v, rout_reg1);
        check_value("regfile_access bypass2", v, rout_reg2);
        // r0 stays zero
        @(posedge clk);
        wb_regwrite <= 1'b1;
        wb_dest_reg <= 5'd0;
        wb_data     <= 32'hffff_ffff;
        @(posedge clk);
        wb_regwrite <= 1'b0;
        present(make_instr(OP_ADDI, 5'd0, 5'd0, 5'd0, FN_ADD), 32'h0);
        check_value("regfile_access r0 port1", 32'h0, rout_reg1);
        check_value("regfile_access r0 port2", 32'h0, rout_reg2);
        end_test("regfile_access");
    endtask

    task automatic raw_stall();
        @(posedge clk);
        instruction <= make_instr(OP_LDW, 5'd3, 5'd4, 5'd5, FN_ADD);
        ex_regwrite <= 1'b1;                     // EX writes src1
        ex_dest_reg <= 5'd3;
        @(negedge clk);
        check_value("raw_stall ex pc_write", 32'(1'b0), 32'(pc_write));
        check_value("raw_stall ex if_id_write", 32'(1'b0), 32'(if_id_write));
        @(posedge clk);
        @(negedge clk);
        check_value("raw_stall ex bubble", 32'(7'b0), 32'(ctrl_out));
        @(posedge clk);
        ex_regwrite <= 1'b0;
        m_regwrite  <= 1'b1;                     // M writes src2
        m_dest_reg  <= 5'd4;
        @(posedge clk);
        @(negedge clk);
        check_value("raw_stall m pc_write", 32'(1'b0), 32'(pc_write));
        check_value("raw_stall m bubble", 32'(7'b0), 32'(ctrl_out));
        @(posedge clk);
        m_regwrite <= 1'b0;
        @(posedge clk);
        @(negedge clk);                          // Held LDW issues
        check_value("raw_stall release ctrl", 32'(expected_ctrl(OP_LDW)), 32'(ctrl_out));
        check_value("raw_stall release pc_write", 32'(1'b1), 32'(pc_write));
        // Match on r0 only
        @(posedge clk);
        instruction <= make_instr(OP_ADDI, 5'd0, 5'd0, 5'd6, FN_ADD);
        ex_regwrite <= 1'b1;
        ex_dest_reg <= 5'd0;
        m_regwrite  <= 1'b1;
        m_dest_reg  <= 5'd0;
        @(negedge clk);
        check_value("raw_stall r0 pc_write", 32'(1'b1), 32'(pc_write));
        @(posedge clk);
        ex_regwrite <= 1'b0;
        m_regwrite  <= 1'b0;
        @(negedge clk);
        check_value("raw_stall r0 ctrl", 32'(expected_ctrl(OP_ADDI)), 32'(ctrl_out));
        end_test("raw_stall");
    endtask

    task automatic mult_spacing();
        logic [31:0] stream [4];
        int          pulse_at [2];
        int          idx;
        int          edge_no;
        int          pulses;
        int          n;
        logic        pw;
        stream[0] = make_instr(OP_RTYPE, 5'd1, 5'd2, 5'd3, FN_MUL);
        stream[1] = make_instr(OP_RTYPE, 5'd4, 5'd5, 5'd6, FN_ADD);
        stream[2] = make_instr(OP_RTYPE, 5'd7, 5'd8, 5'd9, FN_MUL);
        stream[3] = make_instr(OP_NOP, 5'd0, 5'd0, 5'd0, FN_ADD);
        wait_ready("mult_spacing");
        idx     = 0;
        edge_no = 0;
        pulses  = 0;
        n       = 0;
        @(posedge clk);
        instruction <= stream[0];
        pc          <= 32'h100;
        // Fetch model advancing only on pc_write
        while (pulses < 2 && n < 40) begin
            @(negedge clk);
            pw = pc_write;
            if (is_mult === 1'b1) begin
                pulse_at[pulses] = edge_no;      // Issued at this edge
                pulses++;
            end
            if (idx == 1 && pw !== 1'b1) begin
                $display("mult_spacing: ADD between the multiplies was stalled");
                errors++;
            end
            @(posedge clk);
            edge_no++;
            n++;
            if (pw === 1'b1 && idx < 3) begin
                idx++;
            end
            instruction <= stream[idx];
            pc          <= 32'(32'h100 + 4 * idx);
        end
        if (pulses < 2) begin
            $display("mult_spacing: timed out, saw %0d is_mult pulses", pulses);
            errors++;
        end else begin
            check_value("mult_spacing distance", 32'(MULT_CYCLES),
                        32'(pulse_at[1] - pulse_at[0]));
        end
        end_test("mult_spacing");
    endtask

    initial begin
        reset       = 1'b1;
        pc          = 32'h0000_0040;
        // MUL with live fields while in reset
        instruction = make_instr(OP_RTYPE, 5'd0, 5'd0, 5'd7, FN_MUL);
        ex_regwrite = 1'b0;
        ex_dest_reg = '0;
        m_regwrite  = 1'b0;
        m_dest_reg  = '0;
        wb_regwrite = 1'b0;
        wb_dest_reg = '0;
        wb_data     = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        reset_state();
        field_decode();
        immediate_gen();
        regfile_access();
        raw_stall();
        mult_spacing();
        $display("tests %0d, passed %0d, failed %0d, check errors %0d",
                 tests, tests - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/register_file.sv
hdl/control.sv
hdl/hazard_control.sv
hdl/mult_issue_fsm.sv
hdl/mult_latency_timer.sv
hdl/decode_stage.sv
hdl/decode_top.sv
test/decode_tb.sv
